/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module gmii_analyzer_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vgmii_analyzer_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+verilog
verilog/gmii_analyzer_pkg.sv
verilog/gmii_crc_check.sv
verilog/frame_stats.sv
verilog/apb_stat_regs.sv
verilog/gmii_analyzer.sv
tests/gmii_analyzer_assertions.sv
tests/gmii_analyzer_tb.sv

/* tests/gmii_analyzer_assertions.sv */
`include "gmii_analyzer_defines.svh"

module gmii_analyzer_assertions (
    input logic                            clk,
    input logic                            resetn,
    input logic                            psel,
    input logic                            penable,
    input gmii_analyzer_pkg::apb_addr_t    paddr,
    input logic                            pready,
    input logic                            pslverr,
    input gmii_analyzer_pkg::stats_ctrl_t  ctrl,
    input gmii_analyzer_pkg::frame_stats_t stats
);

    timeunit 1ns;
    timeprecision 100ps;

    logic mapped;

    // offsets of the register map
    assign mapped = paddr inside {`REG_ID, `REG_FLIP, `REG_CONTROL, `REG_PKTS, `REG_OCTETS,
                                  `REG_BAD_CRC_PKTS, `REG_BAD_CRC_OCTETS, `REG_BAD_PRE_PKTS,
                                  `REG_BAD_PRE_OCTETS, `REG_FRAME_SIZE};

    // no wait states, error only on an unmapped access
    apb_response: assert property (@(posedge clk) disable iff (!resetn)
        pready && (pslverr == (psel && penable && !mapped)))
        else $error("pready low, or pslverr wrong for the phase and offset");

    // counters only grow while run stays set
    property counters_grow;
        @(posedge clk) disable iff (!resetn)
        (ctrl.run && $past(ctrl.run)) |->
            (stats.pkts >= $past(stats.pkts)) &&
            (stats.octets >= $past(stats.octets)) &&
            (stats.bad_crc_pkts >= $past(stats.bad_crc_pkts)) &&
            (stats.bad_crc_octets >= $past(stats.bad_crc_octets)) &&
            (stats.bad_pre_pkts >= $past(stats.bad_pre_pkts)) &&
            (stats.bad_pre_octets >= $past(stats.bad_pre_octets));
    endproperty

    counters_no_decrease: assert property (counters_grow)
        else $error("statistics counter decreased while run stayed set");

endmodule

bind gmii_analyzer gmii_analyzer_assertions u_assertions (
    .clk     (clk),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr),
    .ctrl    (ctrl),
    .stats   (stats)
);

/* tests/gmii_analyzer_tb.sv */
`include "gmii_analyzer_defines.svh"

module gmii_analyzer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int GAP_CYCLES   = 12;
    localparam int APB_CYCLES   = 3;
    localparam int ROW_APB_OPS  = 8;
    localparam int SETUP_OPS    = 24;
    localparam int NUM_ROWS     = 10;
    localparam int OFF_LEN      = 40;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [31:0] FLIP_VALUE = 32'hA5C3_0F96;

    typedef enum logic [2:0] {
        KIND_GOOD,
        KIND_BAD_FCS,
        KIND_ER_MID,
        KIND_SHORT_PRE,
        KIND_BAD_SFD
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e kind;
        logic [15:0] len;
        logic        freeze;
    } row_t;

    logic                         clk;
    logic                         resetn;
    gmii_analyzer_pkg::gmii_rx_t  rx;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    gmii_analyzer_pkg::apb_addr_t paddr;
    gmii_analyzer_pkg::apb_data_t pwdata;
    gmii_analyzer_pkg::apb_data_t prdata;
    logic                         pready;
    logic                         pslverr;

    row_t                            rows [NUM_ROWS];
    string                           names [NUM_ROWS];
    gmii_analyzer_pkg::frame_stats_t exp_live;
    gmii_analyzer_pkg::frame_stats_t exp_snap;
    logic [31:0]                     lfsr_state;
    int                              check_count;
    int                              mismatch_count;
    int                              cycle_count;
    int                              cycle_limit;

    gmii_analyzer dut0 (
        .clk     (clk),
        .resetn  (resetn),
        .rx      (rx),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic gmii_analyzer_pkg::octet_t random_byte();
        gmii_analyzer_pkg::octet_t v;
        for (int i = 0; i < 8; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // ethernet crc-32, data bits taken lsb first
    function automatic gmii_analyzer_pkg::crc_t crc_update(
        input gmii_analyzer_pkg::crc_t   c,
        input gmii_analyzer_pkg::octet_t d
    );
        gmii_analyzer_pkg::crc_t r;
        logic                    fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ d[i];
            r = {1'b0, r[31:1]};
            if (fb) begin
                r = r ^ 32'hEDB8_8320;
            end
        end
        return r;
    endfunction

    function automatic gmii_analyzer_pkg::apb_data_t ctrl_value(input logic run,
                                                                input logic freeze);
        gmii_analyzer_pkg::apb_data_t v;
        v = '0;
        v[`CTRL_RUN_BIT]    = run;
        v[`CTRL_FREEZE_BIT] = freeze;
        return v;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic apb_write(input gmii_analyzer_pkg::apb_addr_t addr,
                             input gmii_analyzer_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        check_value("apb_write", "pready", 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input gmii_analyzer_pkg::apb_addr_t addr,
                            output gmii_analyzer_pkg::apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // mid low phase of the access cycle
        #(CLK_PERIOD / 4);
        data = prdata;
        err  = pslverr;
        check_value("apb_read", "pready", 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input string test, input string field,
                             input gmii_analyzer_pkg::apb_addr_t addr, input logic [31:0] expected);
        gmii_analyzer_pkg::apb_data_t data;
        logic                         err;
        apb_read(addr, data, err);
        check_value(test, field, expected, data);
        check_value(test, {field, "_pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic check_snapshot(input string test);
        check_reg(test, "pkts", `REG_PKTS, exp_snap.pkts);
        check_reg(test, "octets", `REG_OCTETS, exp_snap.octets);
        check_reg(test, "bad_crc_pkts", `REG_BAD_CRC_PKTS, exp_snap.bad_crc_pkts);
        check_reg(test, "bad_crc_octets", `REG_BAD_CRC_OCTETS, exp_snap.bad_crc_octets);
        check_reg(test, "bad_pre_pkts", `REG_BAD_PRE_PKTS, exp_snap.bad_pre_pkts);
        check_reg(test, "bad_pre_octets", `REG_BAD_PRE_OCTETS, exp_snap.bad_pre_octets);
        check_reg(test, "frame_size", `REG_FRAME_SIZE, {16'd0, exp_snap.last_frame_size});
    endtask

    task automatic send_frame(input frame_kind_e kind, input int len, output int full_len);
        gmii_analyzer_pkg::octet_t octets [$];
        gmii_analyzer_pkg::octet_t b;
        gmii_analyzer_pkg::crc_t   crc;
        int                        pre_len;
        int                        er_pos;
        pre_len = (kind == KIND_SHORT_PRE) ? `PREAMBLE_LEN - 1 : `PREAMBLE_LEN;
        for (int i = 0; i < pre_len; i++) begin
            octets.push_back(`PREAMBLE_OCTET);
        end
        octets.push_back((kind == KIND_BAD_SFD) ? 8'h5D : `SFD_OCTET);
        crc = '1;
        for (int i = 0; i < len; i++) begin
            b = random_byte();
            crc = crc_update(crc, b);
            octets.push_back(b);
        end
        crc = ~crc;
        if (kind == KIND_BAD_FCS) begin
            crc[0] = ~crc[0];
        end
        // fcs goes out low octet first
        for (int i = 0; i < 4; i++) begin
            octets.push_back(crc[8*i +: 8]);
        end
        er_pos = (kind == KIND_ER_MID) ? pre_len + 1 + len / 2 : -1;
        foreach (octets[i]) begin
            @(negedge clk);
            rx.d  = octets[i];
            rx.en = 1'b1;
            rx.er = (i == er_pos);
        end
        @(negedge clk);
        rx = '0;
        repeat (GAP_CYCLES) @(negedge clk);
        full_len = octets.size();
    endtask

    task automatic update_model(input frame_kind_e kind, input int full_len, input logic freeze);
        gmii_analyzer_pkg::count_t full;
        gmii_analyzer_pkg::count_t post;
        full = gmii_analyzer_pkg::count_t'(full_len);
        post = gmii_analyzer_pkg::count_t'(full_len - `PREAMBLE_LEN - 1);
        if (kind == KIND_SHORT_PRE || kind == KIND_BAD_SFD) begin
            exp_live.bad_pre_pkts   = exp_live.bad_pre_pkts + 32'd1;
            exp_live.bad_pre_octets = exp_live.bad_pre_octets + full;
        end else if (kind == KIND_GOOD) begin
            exp_live.pkts   = exp_live.pkts + 32'd1;
            exp_live.octets = exp_live.octets + post;
        end else begin
            exp_live.bad_crc_pkts   = exp_live.bad_crc_pkts + 32'd1;
            exp_live.bad_crc_octets = exp_live.bad_crc_octets + post;
        end
        exp_live.last_frame_size = gmii_analyzer_pkg::frame_len_t'(full_len);
        if (!freeze) begin
            exp_snap = exp_live;
        end
    endtask

    task automatic load_table();
        rows[0] = '{KIND_GOOD, 16'd46, 1'b0};
        names[0] = "good_46";
        rows[1] = '{KIND_GOOD, 16'd60, 1'b0};
        names[1] = "good_60";
        rows[2] = '{KIND_GOOD, 16'd100, 1'b0};
        names[2] = "good_100";
        rows[3] = '{KIND_BAD_FCS, 16'd50, 1'b0};
        names[3] = "bad_fcs_50";
        rows[4] = '{KIND_ER_MID, 16'd64, 1'b0};
        names[4] = "er_mid_64";
        rows[5] = '{KIND_SHORT_PRE, 16'd40, 1'b0};
        names[5] = "short_pre_40";
        rows[6] = '{KIND_BAD_SFD, 16'd30, 1'b0};
        names[6] = "bad_sfd_30";
        // frozen pair, then a thawed frame that catches up
        rows[7] = '{KIND_GOOD, 16'd48, 1'b1};
        names[7] = "frozen_good_48";
        rows[8] = '{KIND_BAD_FCS, 16'd33, 1'b1};
        names[8] = "frozen_bad_fcs_33";
        rows[9] = '{KIND_GOOD, 16'd52, 1'b0};
        names[9] = "thawed_good_52";
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no result after %0d cycles, checks %0d, mismatches %0d",
                 cycle_count, check_count, mismatch_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        gmii_analyzer_pkg::apb_data_t data;
        logic                         err;
        int                           full_len;
        int                           budget;
        rx             = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        resetn         = 1'b0;
        lfsr_state     = 32'h9040;
        check_count    = 0;
        mismatch_count = 0;
        exp_live       = '0;
        exp_snap       = '0;
        load_table();
        budget = RESET_CYCLES + SETUP_OPS * APB_CYCLES + `PREAMBLE_LEN + 5 + OFF_LEN + GAP_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++) begin
            budget = budget + `PREAMBLE_LEN + 5 + int'(rows[r].len) + GAP_CYCLES +
                     ROW_APB_OPS * APB_CYCLES;
        end
        cycle_limit = 2 * budget;

        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;

        apb_read(`REG_ID, data, err);
        check_value("reset_id", "id", `ID_VALUE, data);
        check_value("reset_id", "pslverr", 32'd0, {31'd0, err});
        apb_write(`REG_FLIP, FLIP_VALUE);
        apb_read(`REG_FLIP, data, err);
        check_value("flip", "flip", ~FLIP_VALUE, data);
        apb_read(12'h00C, data, err);
        check_value("unmapped_00c", "pslverr", 32'd1, {31'd0, err});
        apb_read(12'h100, data, err);
        check_value("unmapped_100", "pslverr", 32'd1, {31'd0, err});
        check_snapshot("reset_stats");
        apb_write(`REG_CONTROL, ctrl_value(1'b1, 1'b0));

        for (int r = 0; r < NUM_ROWS; r++) begin
            apb_write(`REG_CONTROL, ctrl_value(1'b1, rows[r].freeze));
            send_frame(rows[r].kind, int'(rows[r].len), full_len);
            update_model(rows[r].kind, full_len, rows[r].freeze);
            check_snapshot(names[r]);
        end

        // run low holds everything at zero, even with traffic
        apb_write(`REG_CONTROL, ctrl_value(1'b0, 1'b0));
        send_frame(KIND_GOOD, OFF_LEN, full_len);
        check_reg("run_off", "pkts", `REG_PKTS, 32'd0);
        check_reg("run_off", "frame_size", `REG_FRAME_SIZE, 32'd0);
        apb_write(`REG_CONTROL, ctrl_value(1'b1, 1'b0));
        exp_live = '0;
        exp_snap = '0;
        check_snapshot("run_restart");

        $display("checks %0d, mismatches %0d", check_count, mismatch_count);
        if (mismatch_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/apb_stat_regs.sv */
`include "gmii_analyzer_defines.svh"

module apb_stat_regs (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  gmii_analyzer_pkg::apb_addr_t    paddr,
    input  gmii_analyzer_pkg::apb_data_t    pwdata,
    output gmii_analyzer_pkg::apb_data_t    prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  gmii_analyzer_pkg::frame_stats_t stats,
    output gmii_analyzer_pkg::stats_ctrl_t  ctrl
);

    gmii_analyzer_pkg::apb_data_t flip;
    gmii_analyzer_pkg::apb_data_t ctrl_word;
    logic                         access;
    logic                         wr_en;
    logic                         hit;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ctrl <= '0;
            flip <= '0;
        end else if (wr_en) begin
            case (paddr)
                `REG_CONTROL: begin
                    ctrl.run    <= pwdata[`CTRL_RUN_BIT];
                    ctrl.freeze <= pwdata[`CTRL_FREEZE_BIT];
                end
                `REG_FLIP: flip <= pwdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[`CTRL_RUN_BIT]    = ctrl.run;
        ctrl_word[`CTRL_FREEZE_BIT] = ctrl.freeze;
    end

    // read mux, also flags unmapped offsets
    always_comb begin
        hit = 1'b1;
        case (paddr)
            `REG_ID:             prdata = `ID_VALUE;
            `REG_FLIP:           prdata = ~flip;
            `REG_CONTROL:        prdata = ctrl_word;
            `REG_PKTS:           prdata = stats.pkts;
            `REG_OCTETS:         prdata = stats.octets;
            `REG_BAD_CRC_PKTS:   prdata = stats.bad_crc_pkts;
            `REG_BAD_CRC_OCTETS: prdata = stats.bad_crc_octets;
            `REG_BAD_PRE_PKTS:   prdata = stats.bad_pre_pkts;
            `REG_BAD_PRE_OCTETS: prdata = stats.bad_pre_octets;
            `REG_FRAME_SIZE:     prdata = gmii_analyzer_pkg::apb_data_t'(stats.last_frame_size);
            default: begin
                prdata = '0;
                hit    = 1'b0;
            end
        endcase
    end

    assign pslverr = access && !hit;

endmodule

/* verilog/frame_stats.sv */
`include "gmii_analyzer_defines.svh"

module frame_stats (
    input  logic                            clk,
    input  logic                            resetn,
    input  gmii_analyzer_pkg::gmii_rx_t     rx,
    input  gmii_analyzer_pkg::frame_check_t check,
    input  gmii_analyzer_pkg::stats_ctrl_t  ctrl,
    output gmii_analyzer_pkg::frame_stats_t stats
);

    gmii_analyzer_pkg::rx_state_e    state;
    gmii_analyzer_pkg::frame_len_t   full_len;
    gmii_analyzer_pkg::frame_len_t   post_len;
    logic                            done;
    logic                            frozen;
    gmii_analyzer_pkg::frame_stats_t live;
    gmii_analyzer_pkg::frame_stats_t live_next;

    // classification of the finished frame
    always_comb begin
        live_next = live;
        if (!check.preamble_ok) begin
            live_next.bad_pre_pkts   = live.bad_pre_pkts + 32'd1;
            live_next.bad_pre_octets = live.bad_pre_octets +
                                       gmii_analyzer_pkg::count_t'(full_len);
        end else if (check.crc_ok) begin
            live_next.pkts   = live.pkts + 32'd1;
            live_next.octets = live.octets + gmii_analyzer_pkg::count_t'(post_len);
        end else begin
            live_next.bad_crc_pkts   = live.bad_crc_pkts + 32'd1;
            live_next.bad_crc_octets = live.bad_crc_octets +
                                       gmii_analyzer_pkg::count_t'(post_len);
        end
        live_next.last_frame_size = full_len;
    end

    always_ff @(posedge clk) begin
        if (!resetn || !ctrl.run) begin
            state    <= gmii_analyzer_pkg::IDLE;
            full_len <= '0;
            post_len <= '0;
            done     <= 1'b0;
            frozen   <= 1'b0;
            live     <= '0;
            stats    <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                gmii_analyzer_pkg::IDLE: begin
                    if (rx.en) begin
                        state    <= gmii_analyzer_pkg::IN_FRAME;
                        full_len <= 16'd1;
                        post_len <= 16'd0;
                        frozen   <= ctrl.freeze;
                    end
                end
                gmii_analyzer_pkg::IN_FRAME: begin
                    if (rx.en) begin
                        full_len <= full_len + 16'd1;
                        // octets past preamble and sfd
                        if (full_len >= `PREAMBLE_LEN + 1) begin
                            post_len <= post_len + 16'd1;
                        end
                    end else begin
                        state <= gmii_analyzer_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= gmii_analyzer_pkg::IDLE;
                end
            endcase

            // lengths and frozen still hold the old frame here,
            // even if the next one starts this cycle
            if (done) begin
                live <= live_next;
                if (!frozen) begin
                    stats <= live_next;
                end
            end
        end
    end

endmodule

/* verilog/gmii_analyzer.sv */
module gmii_analyzer (
    input  logic                         clk,
    input  logic                         resetn,
    input  gmii_analyzer_pkg::gmii_rx_t  rx,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  gmii_analyzer_pkg::apb_addr_t paddr,
    input  gmii_analyzer_pkg::apb_data_t pwdata,
    output gmii_analyzer_pkg::apb_data_t prdata,
    output logic                         pready,
    output logic                         pslverr
);

    gmii_analyzer_pkg::frame_check_t check;
    gmii_analyzer_pkg::stats_ctrl_t  ctrl;
    gmii_analyzer_pkg::frame_stats_t stats;

    gmii_crc_check u_crc_check (
        .clk    (clk),
        .resetn (resetn),
        .rx     (rx),
        .check  (check)
    );

    frame_stats u_frame_stats (
        .clk    (clk),
        .resetn (resetn),
        .rx     (rx),
        .check  (check),
        .ctrl   (ctrl),
        .stats  (stats)
    );

    // host side
    apb_stat_regs u_regs (
        .clk     (clk),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .stats   (stats),
        .ctrl    (ctrl)
    );

endmodule

/* verilog/gmii_analyzer_defines.svh */
`ifndef GMII_ANALYZER_DEFINES_SVH
`define GMII_ANALYZER_DEFINES_SVH

// register byte offsets
`define REG_ID              12'h000
`define REG_FLIP            12'h004
`define REG_CONTROL         12'h008
`define REG_PKTS            12'h010
`define REG_OCTETS          12'h014
`define REG_BAD_CRC_PKTS    12'h018
`define REG_BAD_CRC_OCTETS  12'h01C
`define REG_BAD_PRE_PKTS    12'h020
`define REG_BAD_PRE_OCTETS  12'h024
`define REG_FRAME_SIZE      12'h028

`define ID_VALUE            32'h474D_4131

// control register bits
`define CTRL_RUN_BIT        0
`define CTRL_FREEZE_BIT     1

`define PREAMBLE_OCTET      8'h55
`define SFD_OCTET           8'hD5
`define PREAMBLE_LEN        7

// reflected register value left by a frame with a correct FCS
`define CRC_RESIDUE         32'hDEBB_20E3

`endif

/* verilog/gmii_analyzer_pkg.sv */
package gmii_analyzer_pkg;

    typedef logic [7:0]  octet_t;
    typedef logic [31:0] count_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] crc_t;

    typedef struct packed {
        octet_t d;
        logic   en;
        logic   er;
    } gmii_rx_t;

    typedef struct packed {
        logic preamble_ok;
        logic crc_ok;
    } frame_check_t;

    typedef struct packed {
        logic run;
        logic freeze;
    } stats_ctrl_t;

    typedef struct packed {
        count_t     pkts;
        count_t     octets;
        count_t     bad_crc_pkts;
        count_t     bad_crc_octets;
        count_t     bad_pre_pkts;
        count_t     bad_pre_octets;
        frame_len_t last_frame_size;
    } frame_stats_t;

    typedef enum logic {
        IDLE,
        IN_FRAME
    } rx_state_e;

    typedef enum logic [1:0] {
        SEARCH,
        BODY,
        FAILED
    } pre_state_e;

endpackage

/* verilog/gmii_crc_check.sv */
`include "gmii_analyzer_defines.svh"

module gmii_crc_check (
    input  logic                            clk,
    input  logic                            resetn,
    input  gmii_analyzer_pkg::gmii_rx_t     rx,
    output gmii_analyzer_pkg::frame_check_t check
);

    localparam gmii_analyzer_pkg::crc_t CRC_POLY = 32'hEDB8_8320;

    gmii_analyzer_pkg::pre_state_e state;
    logic [3:0]                    pre_cnt;
    gmii_analyzer_pkg::crc_t       crc;
    logic                          er_seen;
    logic                          frame_end;

    // lsb-first crc-32, one octet per call
    function automatic gmii_analyzer_pkg::crc_t crc_step(
        input gmii_analyzer_pkg::crc_t   c,
        input gmii_analyzer_pkg::octet_t d
    );
        gmii_analyzer_pkg::crc_t r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    // en low after anything but plain idle
    assign frame_end = !rx.en &&
                       ((state != gmii_analyzer_pkg::SEARCH) || (pre_cnt != 4'd0));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= gmii_analyzer_pkg::SEARCH;
            pre_cnt <= 4'd0;
            er_seen <= 1'b0;
            check   <= '0;
        end else if (!rx.en) begin
            if (frame_end) begin
                check.preamble_ok <= (state == gmii_analyzer_pkg::BODY);
                check.crc_ok      <= (state == gmii_analyzer_pkg::BODY) && !er_seen &&
                                     (crc == `CRC_RESIDUE);
            end
            state   <= gmii_analyzer_pkg::SEARCH;
            pre_cnt <= 4'd0;
            er_seen <= 1'b0;
        end else begin
            if (rx.er) begin
                er_seen <= 1'b1;
            end
            if (state == gmii_analyzer_pkg::SEARCH) begin
                if (rx.d == `PREAMBLE_OCTET) begin
                    // saturate so a long preamble cannot wrap back to a valid count
                    if (pre_cnt != 4'hF) begin
                        pre_cnt <= pre_cnt + 4'd1;
                    end
                end else if (rx.d == `SFD_OCTET && pre_cnt == `PREAMBLE_LEN) begin
                    state <= gmii_analyzer_pkg::BODY;
                end else begin
                    state <= gmii_analyzer_pkg::FAILED;
                end
            end
        end
    end

    // crc preset while searching, folded per body octet
    always_ff @(posedge clk) begin
        if (state == gmii_analyzer_pkg::SEARCH) begin
            crc <= '1;
        end else if (state == gmii_analyzer_pkg::BODY && rx.en) begin
            crc <= crc_step(crc, rx.d);
        end
    end

endmodule
